//--- Makefile
# Verilator build and run for the envelope generator testbench

VERILATOR = verilator
TOP       = eg_tb
FLIST     = eg_top.f
VFLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
LINTFLAGS = --lint-only --timing -Wall --top-module $(TOP)
OBJDIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) -o V$(TOP)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)

//--- dv/eg_sva.sv
// bound assertions on the envelope engine: round pulse, pg reset width, output hold
`timescale 1ns/1ns

module eg_sva import eg_phase_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      clk_en,
    input logic      zero,
    input logic      pg_rst,
    input eg_level_t eg_out
);

    logic [4:0] gap; // enabled cycles since the last round pulse

    always_ff @(posedge clk) begin
        if (rst) begin
            gap <= '0;
        end else if (clk_en) begin
            gap <= zero ? 5'd0 : gap + 5'd1;
        end
    end

    ////////////////////
    // round pulse

    zero_period: assert property (@(posedge clk) disable iff (rst)
        (clk_en && zero) |-> (gap == 5'd23))
        else $error("round pulse came after %0d enabled cycles", gap);

    zero_missing: assert property (@(posedge clk) disable iff (rst)
        (clk_en && !zero) |-> (gap < 5'd23))
        else $error("round pulse missing at the last slot");

    // one slot wide only
    pg_single: assert property (@(posedge clk) disable iff (rst)
        (clk_en && pg_rst) |=> !pg_rst)
        else $error("pg_rst high for two enabled cycles");

    out_hold: assert property (@(posedge clk) disable iff (rst)
        !clk_en |=> $stable(eg_out))
        else $error("eg_out changed while clk_en was low");

endmodule

//--- dv/eg_tb.sv
// testbench for eg_top with clock, reset, slot model, stimulus table, checks and timeout
`timescale 1ns/1ns
`include "eg_macros.svh"

module eg_tb;

    localparam int ck_idle  = 0; // silent slot
    localparam int ck_tl    = 1; // level 0 so the output is tl*8
    localparam int ck_rise  = 2; // decay into sustain
    localparam int ck_fall  = 3; // release into silence
    localparam int ck_stall = 4; // clk_en gap and then as ck_tl
    localparam int act_hold = 0;
    localparam int act_on   = 1;
    localparam int act_off  = 2;
    localparam int n_rows   = 7;
    localparam int stall_len = 5;
    localparam int margin   = 200;

    typedef struct {
        int slot;
        int act;
        int arate, drate, srate, rrate, sl, ks, keycode, tl;
        int rounds;
        int check;
    } row_t;

    // what one presented slot should produce
    typedef struct {
        int         slot;
        logic       pg_exp;
        int         check;
        logic [9:0] tl_exp;
        bit         first;
        bit         fin;
        logic [9:0] lo, hi;
    } snap_t;

    logic       clk, rst, clk_en, keyon, pg_rst;
    logic [4:0] arate, drate, srate, keycode;
    logic [3:0] rrate, sl;
    logic [1:0] ks;
    logic [6:0] tl;
    logic [9:0] eg_out;

    row_t       rows [n_rows];
    logic       s_key [`EG_SLOTS];
    logic       key_mem [`EG_SLOTS]; // key state the DUT last saw
    logic [4:0] s_ar [`EG_SLOTS];
    logic [4:0] s_dr [`EG_SLOTS];
    logic [4:0] s_sr [`EG_SLOTS];
    logic [3:0] s_rr [`EG_SLOTS];
    logic [3:0] s_sl [`EG_SLOTS];
    logic [1:0] s_ks [`EG_SLOTS];
    logic [4:0] s_kc [`EG_SLOTS];
    logic [6:0] s_tl [`EG_SLOTS];
    int         s_check [`EG_SLOTS];
    logic [9:0] s_lo [`EG_SLOTS];
    logic [9:0] s_hi [`EG_SLOTS];
    logic [9:0] prev_out [`EG_SLOTS];

    snap_t      drv_q[$];  // driven and not yet taken by the DUT
    snap_t      pipe[$];   // taken with the output still in flight
    bit         prev_en;
    logic [9:0] last_out;
    logic       last_pg;
    int         checks, exp_checks, cycles, limit, seed;

    eg_top UUT (
        .clk (clk), .rst (rst), .clk_en (clk_en), .keyon (keyon),
        .arate (arate), .drate (drate), .srate (srate), .rrate (rrate),
        .sl (sl), .ks (ks), .keycode (keycode), .tl (tl),
        .eg_out (eg_out), .pg_rst (pg_rst)
    );

    bind eg_engine eg_sva u_sva (
        .clk (clk), .rst (rst), .clk_en (clk_en), .zero (zero),
        .pg_rst (pg_rst), .eg_out (eg_out)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run passed %0d cycles", limit);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

    // total level at zero attenuation clamped at silence
    function automatic logic [9:0] tl_level(input logic [6:0] t);
        logic [10:0] sum;
        sum = {1'b0, t, 3'b000};
        return (sum > 11'h3FF) ? 10'h3FF : sum[9:0];
    endfunction

    function automatic logic [9:0] sustain_floor(input int v);
        return (v == 15) ? 10'h3E0 : 10'(v * 32);
    endfunction

    task automatic set_row(input int i, input int slot, input int act, input int ar,
                           input int dr, input int sr, input int rr, input int s_l,
                           input int k_s, input int kc, input int t, input int rounds,
                           input int check);
        rows[i] = '{slot, act, ar, dr, sr, rr, s_l, k_s, kc, t, rounds, check};
    endtask

    ////////////////////
    // one clock with drive at the rising edge and check at the falling edge

    task automatic step(input bit en, input int s, input bit first, input bit fin);
        snap_t      c;
        snap_t      o;
        snap_t      d;
        bit         consumed;
        bit         ok;
        string      msg;
        logic [9:0] exp;
        @(posedge clk);
        consumed = prev_en;
        if (consumed) begin
            c = drv_q.pop_front();
            pipe.push_back(c);
        end
        rst <= 1'b0;
        if (en) begin
            keyon   <= s_key[s];
            arate   <= s_ar[s];
            drate   <= s_dr[s];
            srate   <= s_sr[s];
            rrate   <= s_rr[s];
            sl      <= s_sl[s];
            ks      <= s_ks[s];
            keycode <= s_kc[s];
            tl      <= s_tl[s];
            d.slot   = s;
            d.pg_exp = s_key[s] & ~key_mem[s]; // key-on edge
            key_mem[s] = s_key[s];
            d.check  = s_check[s];
            d.tl_exp = tl_level(s_tl[s]);
            d.first  = first;
            d.fin    = fin;
            d.lo     = s_lo[s];
            d.hi     = s_hi[s];
            drv_q.push_back(d);
        end
        clk_en <= en;
        prev_en = en;
        @(negedge clk);
        ok  = 1'b1;
        msg = "";
        if (!consumed) begin
            // nothing taken so outputs must hold
            if (eg_out !== last_out) begin
                ok  = 1'b0;
                msg = $sformatf("error: eg_out moved from 0x%03h to 0x%03h without clk_en",
                                last_out, eg_out);
            end else if (pg_rst !== last_pg) begin
                ok  = 1'b0;
                msg = $sformatf("error: pg_rst moved from 0x%0h to 0x%0h without clk_en",
                                last_pg, pg_rst);
            end
        end else if (pg_rst !== c.pg_exp) begin
            ok  = 1'b0;
            msg = $sformatf("error: pg_rst slot %0d got 0x%0h expected 0x%0h",
                            c.slot, pg_rst, c.pg_exp);
        end else if (pipe.size() > 3) begin
            o = pipe.pop_front(); // slot taken three edges ago
            checks++;
            if (o.check == ck_rise || o.check == ck_fall) begin
                if (!o.first && eg_out < prev_out[o.slot]) begin
                    ok  = 1'b0;
                    msg = $sformatf("error: eg_out slot %0d fell to 0x%03h from 0x%03h",
                                    o.slot, eg_out, prev_out[o.slot]);
                end else if (o.fin && (eg_out < o.lo || eg_out > o.hi)) begin
                    ok  = 1'b0;
                    msg = $sformatf("error: eg_out slot %0d ended at 0x%03h not 0x%03h..0x%03h",
                                    o.slot, eg_out, o.lo, o.hi);
                end
                prev_out[o.slot] = eg_out;
            end else begin
                exp = (o.check == ck_idle) ? 10'h3FF : o.tl_exp;
                if (eg_out !== exp) begin
                    ok  = 1'b0;
                    msg = $sformatf("error: eg_out slot %0d got 0x%03h expected 0x%03h",
                                    o.slot, eg_out, exp);
                end
            end
        end else if (eg_out !== 10'h3FF) begin
            ok  = 1'b0;
            msg = $sformatf("error: eg_out got 0x%03h expected 0x3ff before the pipe fills",
                            eg_out);
        end
        last_out = eg_out;
        last_pg  = pg_rst;
        assert (ok) else begin
            $display("%s", msg);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic run_row(input int i);
        row_t r;
        int   t;
        r = rows[i];
        t = r.slot;
        if (r.act == act_on) begin
            s_key[t] = 1'b1;
        end else if (r.act == act_off) begin
            s_key[t] = 1'b0;
        end
        s_ar[t] = 5'(r.arate);
        s_dr[t] = 5'(r.drate);
        s_sr[t] = 5'(r.srate);
        s_rr[t] = 4'(r.rrate);
        s_sl[t] = 4'(r.sl);
        s_ks[t] = 2'(r.ks);
        s_kc[t] = 5'(r.keycode);
        s_tl[t] = 7'(r.tl);
        s_check[t] = r.check;
        if (r.check == ck_rise) begin
            s_lo[t] = sustain_floor(r.sl);
            s_hi[t] = sustain_floor(r.sl) + 10'd7; // one step of slack
        end else begin
            s_lo[t] = 10'h3FF;
            s_hi[t] = 10'h3FF;
        end
        if (r.check == ck_stall) begin
            repeat (stall_len) step(1'b0, 0, 1'b0, 1'b0);
        end
        for (int rr = 0; rr < r.rounds; rr++) begin
            for (int s = 0; s < `EG_SLOTS; s++) begin
                step(1'b1, s, (rr == 0) && (s == t), (rr == r.rounds - 1) && (s == t));
            end
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        clk_en   = 1'b1;
        keyon    = 1'b0;
        arate    = '0;
        drate    = '0;
        srate    = '0;
        rrate    = '0;
        sl       = '0;
        ks       = '0;
        keycode  = '0;
        tl       = '0;
        prev_en  = 1'b0;
        last_out = 10'h3FF;
        last_pg  = 1'b0;
        checks   = 0;
        cycles   = 0;
        seed     = 32'h5129_1337;
        for (int s = 0; s < `EG_SLOTS; s++) begin
            s_key[s]   = 1'b0;
            key_mem[s] = 1'b0;
            s_ar[s]    = '0;
            s_dr[s]    = '0;
            s_sr[s]    = '0;
            s_rr[s]    = '0;
            s_sl[s]    = '0;
            s_ks[s]    = '0;
            s_kc[s]    = 5'($random(seed)); // untouched slots stay silent anyway
            s_tl[s]    = 7'($random(seed));
            s_check[s] = ck_idle;
            s_lo[s]    = 10'h3FF;
            s_hi[s]    = 10'h3FF;
            prev_out[s] = 10'h3FF;
        end
        //        slot act       ar  dr  sr  rr  sl ks  kc  tl     rounds check
        set_row(0, 5, act_hold,  0,  0,  0,  0,  0, 0,  0,  0,      2, ck_idle);
        set_row(1, 5, act_on,   31,  0,  0,  0,  0, 0,  0,  8'h20,  3, ck_tl);
        set_row(2, 5, act_hold, 31,  0,  0,  0,  0, 0,  0,  8'h20,  3, ck_tl);
        set_row(3, 5, act_off,  31,  0,  0, 15,  0, 0,  0,  0,    150, ck_fall);
        set_row(4, 5, act_on,   31,  0,  0, 15,  0, 2, 28,  8'h50,  2, ck_tl);
        set_row(5, 12, act_on,  31, 31,  0,  0,  4, 0,  0,  0,     24, ck_rise);
        set_row(6, 5, act_hold, 31,  0,  0, 15,  0, 2, 28,  8'h50,  2, ck_stall);
        exp_checks = 0;
        for (int i = 0; i < n_rows; i++) begin
            exp_checks += rows[i].rounds * `EG_SLOTS;
        end
        limit = exp_checks + margin;

        repeat (2) @(posedge clk); // third reset edge comes with the first step
        for (int i = 0; i < n_rows; i++) begin
            run_row(i);
        end
        // flush the slots still in the pipeline
        for (int s = 0; s < 4; s++) begin
            step(1'b1, s, 1'b0, 1'b0);
        end

        if (checks == exp_checks) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("only %0d of %0d table slot outputs were compared", checks, exp_checks);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

endmodule

//--- eg_top.f
+incdir+include
rtl/eg_phase_pkg.sv
rtl/eg_rate_pkg.sv
rtl/slot_shift.sv
rtl/eg_round_timer.sv
rtl/eg_phase_logic.sv
rtl/eg_rate_step.sv
rtl/eg_level_calc.sv
rtl/eg_engine.sv
rtl/eg_top.sv
dv/eg_sva.sv
dv/eg_tb.sv

//--- include/eg_macros.svh
// envelope generator sizes: slot count, level width, counter width, silence level
`ifndef EG_MACROS_SVH
`define EG_MACROS_SVH

////////////////////
// slot ring

// operator slots served in turn by one engine
`define EG_SLOTS 24

////////////////////
// attenuation

`define EG_LVL_W 10        // level bits, 0 is loudest
`define EG_LVL_MAX 10'h3FF // all ones, silent

////////////////////
// envelope clock

// global counter, one tick per round
`define EG_CNT_W 15

`endif

//--- rtl/eg_engine.sv
// envelope engine with stage II..V registers, circulating slot state and stage blocks
`timescale 1ns/1ns
`include "eg_macros.svh"

module eg_engine import eg_phase_pkg::*, eg_rate_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        clk_en,
    input  logic        zero,
    input  eg_cnt_t     eg_cnt,
    input  logic        keyon,
    input  eg_rate_t    arate,
    input  eg_rate_t    drate,
    input  eg_rate_t    srate,
    input  logic [3:0]  rrate,
    input  logic [3:0]  sl,
    input  logic [1:0]  ks,
    input  eg_keycode_t keycode,
    input  logic [6:0]  tl,
    output eg_level_t   eg_out,
    output logic        pg_rst
);

    // stage I
    logic         key_last;
    logic         keyon_now, keyoff_now;
    logic [1:0]   phase_raw;
    eg_phase_t    phase_in, phase_next;
    eg_level_t    level_i;
    eg_rate_t     base_rate_i;
    logic         pg_rst_i;
    // stage II
    logic         zero_d;
    eg_cnt_t      cnt_ii;       // counter seen by one whole round
    eg_level_t    level_ii;
    logic         attack_ii;
    eg_rate_t     base_rate_ii;
    eg_keycode_t  keycode_ii;
    logic [1:0]   ks_ii;
    logic [6:0]   tl_ii;
    logic         cnt_in, cnt_lsb_ii, step_ii;
    eg_eff_rate_t eff_rate_ii;
    logic [3:0]   step_size_ii;
    // stage III
    eg_level_t    level_iii, level_out_iii;
    logic         attack_iii, step_iii;
    eg_eff_rate_t eff_rate_iii;
    logic [3:0]   step_size_iii;
    logic [6:0]   tl_iii;
    // stage IV
    eg_level_t    level_iv, eg_out_iv;
    logic [6:0]   tl_iv;

    assign keyon_now  = keyon & ~key_last;
    assign keyoff_now = ~keyon & key_last;
    assign phase_in   = eg_phase_t'(phase_raw);

    eg_phase_logic u_phase (
        .keyon_now  (keyon_now),
        .keyoff_now (keyoff_now),
        .phase_in   (phase_in),
        .level_in   (level_i),
        .arate      (arate),
        .drate      (drate),
        .srate      (srate),
        .rrate      (rrate),
        .sl         (sl),
        .phase_next (phase_next),
        .base_rate  (base_rate_i),
        .pg_rst     (pg_rst_i)
    );

    eg_rate_step u_rate (
        .base_rate (base_rate_ii),
        .keycode   (keycode_ii),
        .ks        (ks_ii),
        .eg_cnt    (cnt_ii),
        .cnt_in    (cnt_in),
        .eff_rate  (eff_rate_ii),
        .step      (step_ii),
        .cnt_lsb   (cnt_lsb_ii),
        .step_size (step_size_ii)
    );

    eg_level_calc u_level (
        .attack      (attack_iii),
        .step        (step_iii),
        .eff_rate    (eff_rate_iii),
        .step_size   (step_size_iii),
        .level_in    (level_iii),
        .level_out   (level_out_iii),
        .tl          (tl_iv),
        .final_level (level_iv),
        .eg_out      (eg_out_iv)
    );

    ////////////////////
    // pipeline registers

    always_ff @(posedge clk) begin
        if (rst) begin
            zero_d        <= 1'b0;
            cnt_ii        <= '0;
            level_ii      <= `EG_LVL_MAX;
            attack_ii     <= 1'b0;
            base_rate_ii  <= '0;
            keycode_ii    <= '0;
            ks_ii         <= '0;
            tl_ii         <= '0;
            pg_rst        <= 1'b0;
            level_iii     <= `EG_LVL_MAX;
            attack_iii    <= 1'b0;
            step_iii      <= 1'b0;
            eff_rate_iii  <= '0;
            step_size_iii <= '0;
            tl_iii        <= '0;
            level_iv      <= `EG_LVL_MAX;
            tl_iv         <= '0;
            eg_out        <= `EG_LVL_MAX;
        end else if (clk_en) begin
            zero_d <= zero;
            if (zero_d) begin
                cnt_ii <= eg_cnt; // slot 0 enters stage II next
            end
            level_ii      <= level_i;
            attack_ii     <= (phase_next == ph_attack);
            base_rate_ii  <= base_rate_i;
            keycode_ii    <= keycode;
            ks_ii         <= ks;
            tl_ii         <= tl;
            pg_rst        <= pg_rst_i;
            level_iii     <= level_ii;
            attack_iii    <= attack_ii;
            step_iii      <= step_ii;
            eff_rate_iii  <= eff_rate_ii;
            step_size_iii <= step_size_ii;
            tl_iii        <= tl_ii;
            level_iv      <= level_out_iii; // updated level
            tl_iv         <= tl_iii;
            eg_out        <= eg_out_iv;     // stage V
        end
    end

    ////////////////////
    // slot state lines

    slot_shift #(.width(1), .stages(`EG_SLOTS), .rst_ones(1'b0)) u_key_sh (
        .clk (clk), .rst (rst), .clk_en (clk_en),
        .din (keyon), .dout (key_last)
    );

    slot_shift #(.width(2), .stages(`EG_SLOTS), .rst_ones(1'b1)) u_phase_sh (
        .clk (clk), .rst (rst), .clk_en (clk_en),
        .din (phase_next), .dout (phase_raw)
    );

    // three stages already held by the pipeline registers
    slot_shift #(.width(10), .stages(`EG_SLOTS - 3), .rst_ones(1'b1)) u_level_sh (
        .clk (clk), .rst (rst), .clk_en (clk_en),
        .din (level_iv), .dout (level_i)
    );

    slot_shift #(.width(1), .stages(`EG_SLOTS), .rst_ones(1'b0)) u_cnt_sh (
        .clk (clk), .rst (rst), .clk_en (clk_en),
        .din (cnt_lsb_ii), .dout (cnt_in)
    );

endmodule

//--- rtl/eg_level_calc.sv
// stage III level update and stage IV total level with saturation
`timescale 1ns/1ns
`include "eg_macros.svh"

module eg_level_calc import eg_phase_pkg::*, eg_rate_pkg::*; (
    input  logic         attack,
    input  logic         step,
    input  eg_eff_rate_t eff_rate,
    input  logic [3:0]   step_size,
    input  eg_level_t    level_in,
    output eg_level_t    level_out,
    input  logic [6:0]   tl,
    input  eg_level_t    final_level,
    output eg_level_t    eg_out
);

    logic [6:0]  ar_frac; // level/16 + 1
    logic [10:0] ar_dec;
    logic [10:0] dr_sum;
    logic [10:0] tl_sum;

    ////////////////////
    // stage III

    assign ar_frac = {1'b0, level_in[9:4]} + 7'd1;
    assign ar_dec  = 11'(ar_frac) * 11'(step_size); // at most 64*15
    assign dr_sum  = {1'b0, level_in} + {7'd0, step_size};

    always_comb begin
        level_out = level_in;
        if (attack) begin
            if (eff_rate >= 6'd62) begin
                level_out = '0; // instant attack
            end else if (step) begin
                // exponential approach toward 0
                if (ar_dec >= {1'b0, level_in}) begin
                    level_out = '0;
                end else begin
                    level_out = level_in - ar_dec[9:0];
                end
            end
        end else if (step) begin
            level_out = dr_sum[10] ? `EG_LVL_MAX : dr_sum[9:0];
        end
    end

    ////////////////////
    // stage IV

    assign tl_sum = {1'b0, final_level} + {1'b0, tl, 3'b000};
    assign eg_out = tl_sum[10] ? `EG_LVL_MAX : tl_sum[9:0]; // clamp at silence

endmodule

//--- rtl/eg_phase_logic.sv
// stage I: key edges and level to next envelope phase, base rate, pg reset
`timescale 1ns/1ns

module eg_phase_logic import eg_phase_pkg::*, eg_rate_pkg::*; (
    input  logic       keyon_now,
    input  logic       keyoff_now,
    input  eg_phase_t  phase_in,
    input  eg_level_t  level_in,
    input  eg_rate_t   arate,
    input  eg_rate_t   drate,
    input  eg_rate_t   srate,
    input  logic [3:0] rrate,
    input  logic [3:0] sl,
    output eg_phase_t  phase_next,
    output eg_rate_t   base_rate,
    output logic       pg_rst
);

    eg_level_t sl_level; // decay to sustain threshold
    logic      sl_hit;

    ////////////////////
    // sustain level

    // sl 15 maps to the top step instead of 0x1E0
    assign sl_level = {((&sl) ? 5'h1f : {1'b0, sl}), 5'd0};
    assign sl_hit   = (level_in >= sl_level);

    ////////////////////
    // phase transitions

    always_comb begin
        phase_next = phase_in;
        if (keyon_now) begin
            phase_next = ph_attack; // restart from whatever level is there
        end else if (keyoff_now) begin
            phase_next = ph_release;
        end else begin
            case (phase_in)
                ph_attack: begin
                    if (level_in == '0) begin
                        phase_next = ph_decay;
                    end
                end
                ph_decay: begin
                    if (sl_hit) begin
                        phase_next = ph_sustain;
                    end
                end
                default: phase_next = phase_in; // sustain and release hold
            endcase
        end
    end

    // rate of the phase just chosen
    always_comb begin
        case (phase_next)
            ph_attack:  base_rate = arate;
            ph_decay:   base_rate = drate;
            ph_sustain: base_rate = srate;
            default:    base_rate = {rrate, 1'b1}; // release, 2*rr+1
        endcase
    end

    assign pg_rst = keyon_now; // phase generator restarts on key-on edge

endmodule

//--- rtl/eg_phase_pkg.sv
// envelope phase enum and attenuation level type
`include "eg_macros.svh"

package eg_phase_pkg;

    // per-slot phase, release doubles as the idle phase
    typedef enum logic [1:0] {
        ph_attack  = 2'd0,
        ph_decay   = 2'd1,
        ph_sustain = 2'd2,
        ph_release = 2'd3  // all ones, matches the state line reset
    } eg_phase_t;

    // attenuation, 0 loudest and all ones silent
    typedef logic [`EG_LVL_W-1:0] eg_level_t;

endpackage

//--- rtl/eg_rate_pkg.sv
// rate, key-code and envelope counter types
`include "eg_macros.svh"

package eg_rate_pkg;

    // base rate from the slot settings, 0 freezes the level
    typedef logic [4:0] eg_rate_t;

    // rate after key scaling, 0..63
    typedef logic [5:0] eg_eff_rate_t;

    typedef logic [4:0] eg_keycode_t; // block and note bits

    // global envelope counter
    typedef logic [`EG_CNT_W-1:0] eg_cnt_t;

endpackage

//--- rtl/eg_rate_step.sv
// stage II: key-scaled rate, counter driven step decision and step size
`timescale 1ns/1ns

module eg_rate_step import eg_rate_pkg::*; (
    input  eg_rate_t     base_rate,
    input  logic [4:0]   keycode,
    input  logic [1:0]   ks,
    input  eg_cnt_t      eg_cnt,
    input  logic         cnt_in,
    output eg_eff_rate_t eff_rate,
    output logic         step,
    output logic         cnt_lsb,
    output logic [3:0]   step_size
);

    logic [4:0] ks_kc;     // keycode share after key scaling
    logic [6:0] pre_rate;  // one bit of headroom
    logic [3:0] rate_hi;
    logic [3:0] cnt_shift;
    eg_cnt_t    cnt_sh;
    logic [2:0] cnt;       // counter window for this rate
    logic [7:0] pattern;
    logic       sum_up;

    ////////////////////
    // effective rate

    assign ks_kc    = keycode >> (2'd3 - ks);
    assign pre_rate = (base_rate == '0) ? 7'd0
                    : {1'b0, base_rate, 1'b0} + {2'b0, ks_kc};
    assign eff_rate = pre_rate[6] ? 6'd63 : pre_rate[5:0];

    ////////////////////
    // counter window

    assign rate_hi   = eff_rate[5:2];
    // faster rates look at lower counter bits, 48 and up use bits 2:0
    assign cnt_shift = (rate_hi >= 4'd12) ? 4'd0 : 4'd12 - rate_hi;
    assign cnt_sh    = eg_cnt >> cnt_shift;
    assign cnt       = cnt_sh[2:0];

    always_comb begin
        case (eff_rate[1:0])
            2'd0:    pattern = 8'b1010_1010; // 4 of 8
            2'd1:    pattern = 8'b1110_1010;
            2'd2:    pattern = 8'b1110_1110;
            default: pattern = 8'b1111_1110; // 7 of 8
        endcase
    end

    // step only once per change of the window LSB
    assign sum_up  = (cnt[0] != cnt_in);
    assign cnt_lsb = cnt[0];

    always_comb begin
        if (eff_rate[5:1] == 5'd0) begin
            step = 1'b0;               // rates 0 and 1 never move
        end else if (rate_hi >= 4'd12) begin
            step = sum_up;             // every round
        end else begin
            step = sum_up & pattern[cnt];
        end
    end

    always_comb begin
        case (rate_hi)
            4'd12:   step_size = 4'd2;
            4'd13:   step_size = 4'd4;
            4'd14,
            4'd15:   step_size = 4'd8;
            default: step_size = 4'd1;
        endcase
    end

endmodule

//--- rtl/eg_round_timer.sv
// slot position counter, round pulse and global envelope counter
`timescale 1ns/1ns
`include "eg_macros.svh"

module eg_round_timer import eg_rate_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    clk_en,
    output logic    zero,
    output eg_cnt_t eg_cnt
);

    localparam int slot_w = $clog2(`EG_SLOTS);

    logic [slot_w-1:0] slot_cnt; // slot now at stage I

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_cnt <= '0;
            zero     <= 1'b0;
            eg_cnt   <= '0;
        end else if (clk_en) begin
            if (slot_cnt == slot_w'(`EG_SLOTS - 1)) begin
                slot_cnt <= '0;
            end else begin
                slot_cnt <= slot_cnt + 1'b1;
            end
            // high while the last slot sits at stage I
            zero <= (slot_cnt == slot_w'(`EG_SLOTS - 2));
            if (zero) begin
                eg_cnt <= eg_cnt + 1'b1; // envelope clock, once a round
            end
        end
    end

endmodule

//--- rtl/eg_top.sv
// envelope generator top: round timer and engine
`timescale 1ns/1ns

module eg_top import eg_phase_pkg::*, eg_rate_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        clk_en,
    input  logic        keyon,
    input  eg_rate_t    arate,
    input  eg_rate_t    drate,
    input  eg_rate_t    srate,
    input  logic [3:0]  rrate,
    input  logic [3:0]  sl,
    input  logic [1:0]  ks,
    input  eg_keycode_t keycode,
    input  logic [6:0]  tl,
    output eg_level_t   eg_out,
    output logic        pg_rst
);

    logic    zero;   // last slot at stage I
    eg_cnt_t eg_cnt;

    eg_round_timer u_timer (
        .clk    (clk),
        .rst    (rst),
        .clk_en (clk_en),
        .zero   (zero),
        .eg_cnt (eg_cnt)
    );

    eg_engine u_engine (
        .clk     (clk),
        .rst     (rst),
        .clk_en  (clk_en),
        .zero    (zero),
        .eg_cnt  (eg_cnt),
        .keyon   (keyon),
        .arate   (arate),
        .drate   (drate),
        .srate   (srate),
        .rrate   (rrate),
        .sl      (sl),
        .ks      (ks),
        .keycode (keycode),
        .tl      (tl),
        .eg_out  (eg_out),
        .pg_rst  (pg_rst)
    );

endmodule

//--- rtl/slot_shift.sv
// per-slot delay line with enable and synchronous reset fill
`timescale 1ns/1ns

module slot_shift #(
    parameter int width    = 1,
    parameter int stages   = 24,
    parameter bit rst_ones = 1'b0  // reset fill value
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             clk_en,
    input  logic [width-1:0] din,
    output logic [width-1:0] dout
);

    logic [width-1:0] sh [stages];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < stages; i++) begin
                sh[i] <= rst_ones ? '1 : '0;
            end
        end else if (clk_en) begin
            sh[0] <= din;
            for (int i = 1; i < stages; i++) begin
                sh[i] <= sh[i-1];
            end
        end
    end

    assign dout = sh[stages-1]; // oldest entry

endmodule
